/* verilog/console_pkg.sv */
`default_nettype none

package console_pkg;

  // Receiver samples per bit period
  localparam int unsigned OVERSAMPLE = 16;

  // Console rate per switch code, code 8 is the card default
  localparam int unsigned BAUD_TABLE [16] = '{
    110, 150, 300, 600,
    1200, 2400, 4800, 7200,
    9600, 19200, 38400, 57600,
    115200,
    9600, 9600, 9600  // Unused codes fall back to 9600
  };

  // Operator console characters
  localparam logic [7:0] CH_RUN    = 8'h52;  // "R" starts the machine
  localparam logic [7:0] CH_ESC    = 8'h1B;  // Back to OPCOM
  localparam logic [7:0] CH_PROMPT = 8'h40;  // "@"
  localparam logic [7:0] CH_ERROR  = 8'h3F;  // "?" on framing error

  typedef logic [3:0] baud_sel_t;  // Baud rate switch
  typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

/* verilog/baud_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module baud_gen #(
  parameter int unsigned CLK_HZ = 39_321_600
) (
  input  wire                    sysclk,
  input  wire                    rst_n,
  input  wire console_pkg::baud_sel_t baud_sel,  // Switch code
  output logic                   tick            // One cycle per 1/16 bit
);

  // Slowest rate sets the counter width
  localparam int unsigned DIV_MAX =
    CLK_HZ / (console_pkg::OVERSAMPLE * console_pkg::BAUD_TABLE[0]);
  localparam int unsigned DIV_W = $clog2(DIV_MAX + 1);

  logic [DIV_W-1:0] div_tab [16];  // Divisor per switch code
  logic [DIV_W-1:0] div;
  logic [DIV_W-1:0] cnt;

  // Constant divisors, folded at elaboration
  for (genvar i = 0; i < 16; i++) begin : g_div
    assign div_tab[i] =
      DIV_W'(CLK_HZ / (console_pkg::OVERSAMPLE * console_pkg::BAUD_TABLE[i]));
  end

  assign div = div_tab[baud_sel];

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (cnt == '0) begin
        cnt  <= div - 1'b1;  // New switch value picked up here
        tick <= 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Clock too slow for the selected rate
  a_div_nonzero: assert property (@(posedge sysclk) disable iff (!rst_n) div != '0);

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  wire                sysclk,
  input  wire                rst_n,
  input  wire                tick,          // 16x bit rate
  input  wire                rxd,           // Async serial line
  output logic               rx_valid,      // Byte strobe
  output console_pkg::byte_t rx_data,
  output logic               rx_frame_err   // Stop bit sampled low
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t  state;
  logic       rxd_s1;    // Synchronizer stages
  logic       rxd_s2;
  logic       rxd_d;     // Previous synced level
  logic [3:0] tick_cnt;  // Ticks within a bit
  logic [2:0] bit_cnt;   // Data bit index

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_s1 <= 1'b1;  // Idle line is high
      rxd_s2 <= 1'b1;
      rxd_d  <= 1'b1;
    end else begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
      rxd_d  <= rxd_s2;
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= S_IDLE;
      tick_cnt     <= '0;
      bit_cnt      <= '0;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
      case (state)
        S_IDLE: begin
          // Falling edge only, so a held-low line after an error waits
          if (rxd_d && !rxd_s2) begin
            state    <= S_START;
            tick_cnt <= '0;
          end
        end
        S_START: begin
          if (tick) begin
            if (tick_cnt == 4'd7) begin  // Middle of start bit
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rxd_s2 ? S_IDLE : S_DATA;  // Glitch rejected
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        S_DATA: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;  // Wraps every bit
            if (tick_cnt == 4'd15) begin
              rx_data <= {rxd_s2, rx_data[7:1]};  // LSB first
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7) state <= S_STOP;
            end
          end
        end
        S_STOP: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == 4'd15) begin  // Mid stop bit
              rx_valid     <= rxd_s2;
              rx_frame_err <= !rxd_s2;
              state        <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire                sysclk,
  input  wire                rst_n,
  input  wire                tick,      // 16x bit rate
  input  wire                tx_start,  // Load strobe
  input  wire console_pkg::byte_t tx_data,
  output logic               txd,
  output logic               tx_busy
);

  logic [9:0] frame;     // Stop, data, start
  logic       line_on;   // Start bit reached the line
  logic [3:0] tick_cnt;
  logic [3:0] bit_cnt;   // 0 = start, 9 = stop

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      txd      <= 1'b1;
      tx_busy  <= 1'b0;
      line_on  <= 1'b0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tx_start) begin
      tx_busy  <= 1'b1;
      line_on  <= 1'b0;  // Wait for the next tick
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tx_busy && tick) begin
      if (!line_on) begin
        line_on <= 1'b1;
        txd     <= frame[0];  // Start bit
      end else if (tick_cnt == 4'd15) begin
        tick_cnt <= '0;
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == 4'd9) begin  // Stop bit done
          tx_busy <= 1'b0;
          line_on <= 1'b0;
          txd     <= 1'b1;
        end else begin
          txd <= frame[1];
        end
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Frame shift register
  always_ff @(posedge sysclk) begin
    if (tx_start) begin
      frame <= {1'b1, tx_data, 1'b0};
    end else if (tx_busy && tick && line_on && tick_cnt == 4'd15) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

  a_no_start_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

`default_nettype wire

/* verilog/console_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module console_ctrl (
  input  wire                sysclk,
  input  wire                rst_n,
  input  wire                stop_btn,      // Active low, async
  input  wire                rx_valid,
  input  wire console_pkg::byte_t rx_data,
  input  wire                rx_frame_err,
  input  wire                tx_busy,
  output logic               tx_start,
  output console_pkg::byte_t tx_data,
  output logic               run,           // 1 = RUN, 0 = OPCOM
  output logic               error          // Framing error seen
);

  logic               btn_s1;      // Stop button synchronizer
  logic               btn_s2;
  logic               btn_d;
  logic               stop_fall;   // Press detected
  logic               reply_req;
  console_pkg::byte_t reply_byte;
  logic               pend_full;   // One-byte reply buffer
  console_pkg::byte_t pend_data;
  logic               tx_go;

  assign stop_fall = btn_d & ~btn_s2;
  // tx_busy lags tx_start by a cycle, hence the tx_start term
  assign tx_go = pend_full & ~tx_busy & ~tx_start;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      btn_s1 <= 1'b1;  // Released
      btn_s2 <= 1'b1;
      btn_d  <= 1'b1;
    end else begin
      btn_s1 <= stop_btn;
      btn_s2 <= btn_s1;
      btn_d  <= btn_s2;
    end
  end

  // Reply selection
  always_comb begin
    reply_req  = 1'b0;
    reply_byte = rx_data;  // Echo by default
    if (rx_frame_err) begin
      reply_req  = 1'b1;
      reply_byte = console_pkg::CH_ERROR;
    end else if (rx_valid && !run) begin
      reply_req = 1'b1;  // OPCOM echo
    end else if (rx_valid && rx_data == console_pkg::CH_ESC) begin
      reply_req  = 1'b1;  // Escape from RUN
      reply_byte = console_pkg::CH_PROMPT;
    end else if (stop_fall && run) begin
      reply_req  = 1'b1;
      reply_byte = console_pkg::CH_PROMPT;
    end
  end

  // RUN/OPCOM state and error flag
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      run   <= 1'b0;
      error <= 1'b0;
    end else if (rx_frame_err) begin
      error <= 1'b1;
    end else if (rx_valid && !run && rx_data == console_pkg::CH_RUN) begin
      run   <= 1'b1;
      error <= 1'b0;  // Start clears the error LED
    end else if (run && ((rx_valid && rx_data == console_pkg::CH_ESC) || stop_fall)) begin
      run <= 1'b0;
    end
  end

  // Pending buffer and transmit strobe
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      pend_full <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      tx_start <= tx_go;
      if (reply_req) begin
        pend_full <= 1'b1;  // New reply wins over the drain
      end else if (tx_go) begin
        pend_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (reply_req) pend_data <= reply_byte;
    if (tx_go) tx_data <= pend_data;
  end

  // Replies arrive no faster than one per character time
  a_pend_no_overwrite: assert property (@(posedge sysclk) disable iff (!rst_n)
    reply_req |-> (!pend_full || tx_go));

endmodule

`default_nettype wire

/* verilog/led_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module led_driver #(
  parameter int unsigned STRETCH_CYCLES = 3_932_160
) (
  input  wire        sysclk,
  input  wire        rst_n,
  input  wire        run,
  input  wire        error,
  input  wire        rx_pulse,  // Byte received
  input  wire        tx_pulse,  // Byte sent
  output logic [5:0] led        // Active low
);

  localparam int unsigned CNT_W = $clog2(STRETCH_CYCLES + 1);

  logic [1:0] pulse;   // 0 = RX, 1 = TX
  logic [1:0] active;  // Stretched activity

  assign pulse = {tx_pulse, rx_pulse};

  for (genvar i = 0; i < 2; i++) begin : g_stretch
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
        cnt <= '0;
      end else if (pulse[i]) begin
        cnt <= CNT_W'(STRETCH_CYCLES);  // Retrigger
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end

    assign active[i] = (cnt != '0);
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      led <= 6'b111011;  // OPCOM only
    end else begin
      led <= {~active[1],  // TX activity
              ~active[0],  // RX activity
              1'b1,        // Heartbeat off
              run,         // OPCOM lit when not running
              ~run,
              ~error};
    end
  end

endmodule

`default_nettype wire

/* verilog/nd_console_top.sv */
`timescale 1ns/10ps
`default_nettype none

module nd_console_top #(
  parameter int unsigned CLK_HZ         = 39_321_600,  // XTAL1
  parameter int unsigned STRETCH_CYCLES = 3_932_160    // About 100 ms
) (
  input  wire                    sysclk,
  input  wire                    rst_n,
  input  wire                    stop_btn,  // Active low
  input  wire                    uart_rx,
  input  wire console_pkg::baud_sel_t baud_sel,
  output logic                   uart_tx,
  output logic [5:0]             led,
  output logic                   run        // 0 = OPCOM
);

  logic               tick;
  logic               rx_valid;
  logic               rx_frame_err;
  console_pkg::byte_t rx_data;
  logic               tx_start;
  logic               tx_busy;
  console_pkg::byte_t tx_data;
  logic               error;

  baud_gen #(.CLK_HZ(CLK_HZ)) i_baud_gen (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .baud_sel(baud_sel),
    .tick    (tick)
  );

  uart_rx i_uart_rx (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .tick        (tick),
    .rxd         (uart_rx),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_frame_err(rx_frame_err)
  );

  uart_tx i_uart_tx (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .tick    (tick),
    .tx_start(tx_start),
    .tx_data (tx_data),
    .txd     (uart_tx),
    .tx_busy (tx_busy)
  );

  console_ctrl i_console_ctrl (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .stop_btn    (stop_btn),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_frame_err(rx_frame_err),
    .tx_busy     (tx_busy),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .run         (run),
    .error       (error)
  );

  // Activity from the byte strobes, not the raw lines
  led_driver #(.STRETCH_CYCLES(STRETCH_CYCLES)) i_led_driver (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .run     (run),
    .error   (error),
    .rx_pulse(rx_valid),
    .tx_pulse(tx_start),
    .led     (led)
  );

endmodule

`default_nettype wire

/* verification/tb_nd_console_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_nd_console_top;

  localparam int unsigned CLK_HZ         = 1_843_200;  // 9600 baud divides by 12
  localparam int unsigned STRETCH_CYCLES = 64;
  localparam int unsigned SEED           = 32'h3deb_940b;
  localparam console_pkg::baud_sel_t SEL_DEF  = 4'd8;   // 9600, card default
  localparam console_pkg::baud_sel_t SEL_FAST = 4'd12;  // 115200
  // 6 tests, up to 12 characters each, 20 bit periods per character at 9600
  localparam int unsigned TIMEOUT_CYCLES =
    6 * 12 * 20 * 16 * (CLK_HZ / (16 * console_pkg::BAUD_TABLE[SEL_DEF]));

  logic                   sysclk;
  logic                   rst_n;
  logic                   stop_btn;  // Active low
  logic                   uart_rx;
  console_pkg::baud_sel_t baud_sel;
  wire                    uart_tx;
  wire  [5:0]             led;
  wire                    run;

  int unsigned cycle_cnt = 0;
  int          err_cnt = 0;
  int          test_err_base;  // Error count when the current test began
  int          tests_passed = 0;
  int          tests_failed = 0;

  nd_console_top #(
    .CLK_HZ        (CLK_HZ),
    .STRETCH_CYCLES(STRETCH_CYCLES)
  ) i_nd_console_top (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .stop_btn(stop_btn),
    .uart_rx (uart_rx),
    .baud_sel(baud_sel),
    .uart_tx (uart_tx),
    .led     (led),
    .run     (run)
  );

  initial sysclk = 1'b0;
  always #5 sysclk = ~sysclk;  // 10 ns period

  always @(posedge sysclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, run stopped", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Clock cycles per bit, 16 ticks of integer spacing
  function automatic int unsigned bit_cycles(console_pkg::baud_sel_t sel);
    return 16 * (CLK_HZ / (16 * console_pkg::BAUD_TABLE[sel]));
  endfunction

  // Active-low LED image with activity idle
  function automatic logic [5:0] led_expect(logic run_e, logic err_e);
    return {1'b1,    // TX activity off
            1'b1,    // RX activity off
            1'b1,    // Heartbeat held high
            run_e,   // OPCOM lit when stopped
            ~run_e,  // RUN
            ~err_e};
  endfunction

  // Any byte except the two command characters
  function automatic console_pkg::byte_t random_char();
    console_pkg::byte_t c;
    c = console_pkg::byte_t'($urandom);
    while (c == console_pkg::CH_RUN || c == console_pkg::CH_ESC)
      c = console_pkg::byte_t'($urandom);
    return c;
  endfunction

  task automatic check_byte(input string name, input console_pkg::byte_t expected,
                            input console_pkg::byte_t actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected 8'h%h actual 8'h%h", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic check_led(input string name, input logic [5:0] expected,
                           input logic [5:0] actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected 6'b%b actual 6'b%b", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  // 8N1 frame at the current switch rate, stop bit optionally low
  task automatic send_byte(input console_pkg::byte_t data, input logic bad_stop);
    logic [9:0]  frame;
    int unsigned n;
    frame = {~bad_stop, data, 1'b0};  // Stop, data, start
    n = bit_cycles(baud_sel);
    @(negedge sysclk);
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (n) @(negedge sysclk);
    end
    uart_rx = 1'b1;  // Back to idle
  endtask

  // Waits for a start bit, then samples each bit in its middle
  task automatic expect_byte(input logic rx_act, output console_pkg::byte_t data,
                             output logic found);
    int unsigned n;
    int unsigned waited;
    n = bit_cycles(baud_sel);
    data = '0;
    found = 1'b0;
    waited = 0;
    while (uart_tx !== 1'b0 && waited < 12 * n) begin
      @(negedge sysclk);
      waited++;
    end
    if (uart_tx !== 1'b0) begin
      $display("t=%0t no start bit on uart_tx within %0d cycles", $time, 12 * n);
      err_cnt++;
    end else begin
      found = 1'b1;
      // Strobes just before the start bit still stretched
      check_bit("led[5] tx activity", 1'b0, led[5]);
      check_bit("led[4] rx activity", ~rx_act, led[4]);
      repeat (n / 2) @(negedge sysclk);  // Mid start bit
      check_bit("uart_tx start bit", 1'b0, uart_tx);
      for (int i = 0; i < 8; i++) begin
        repeat (n) @(negedge sysclk);
        data[i] = uart_tx;  // LSB first
      end
      repeat (n) @(negedge sysclk);
      check_bit("uart_tx stop bit", 1'b1, uart_tx);
    end
  endtask

  // Send one byte and check the reply on the line at the same time
  task automatic exchange(input console_pkg::byte_t send, input logic bad_stop,
                          input console_pkg::byte_t reply);
    console_pkg::byte_t got;
    logic               found;
    fork
      send_byte(send, bad_stop);
      expect_byte(~bad_stop, got, found);  // Only a good byte strobes rx_valid
    join
    if (found) check_byte("uart_tx byte", reply, got);
  endtask

  task automatic expect_quiet(input int unsigned cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge sysclk);
      if (uart_tx !== 1'b1) begin
        check_bit("uart_tx idle", 1'b1, uart_tx);
        break;  // One report per window
      end
    end
  endtask

  task automatic report_test(input string name);
    if (err_cnt == test_err_base) begin
      $display("Test %s: pass", name);
      tests_passed++;
    end else begin
      $display("Test %s: fail, %0d errors", name, err_cnt - test_err_base);
      tests_failed++;
    end
    test_err_base = err_cnt;
  endtask

  task automatic test_reset();
    check_bit("uart_tx", 1'b1, uart_tx);
    check_bit("run", 1'b0, run);
    check_led("led", led_expect(1'b0, 1'b0), led);
    report_test("reset");
  endtask

  task automatic test_opcom_echo();
    console_pkg::byte_t c;
    repeat (8) begin
      c = random_char();
      exchange(c, 1'b0, c);
      check_bit("run", 1'b0, run);
    end
    report_test("opcom_echo");
  endtask

  task automatic test_run_escape();
    console_pkg::byte_t a;
    console_pkg::byte_t b;
    int unsigned        n;
    a = random_char();
    b = random_char();
    n = bit_cycles(baud_sel);
    exchange(console_pkg::CH_RUN, 1'b0, console_pkg::CH_RUN);
    check_bit("run", 1'b1, run);
    fork
      begin
        send_byte(a, 1'b0);
        send_byte(b, 1'b0);
      end
      expect_quiet(20 * n);  // Two character times
    join
    exchange(console_pkg::CH_ESC, 1'b0, console_pkg::CH_PROMPT);
    check_bit("run", 1'b0, run);
    report_test("run_escape");
  endtask

  task automatic test_stop_button();
    console_pkg::byte_t got;
    logic               found;
    exchange(console_pkg::CH_RUN, 1'b0, console_pkg::CH_RUN);
    check_bit("run", 1'b1, run);
    @(negedge sysclk);
    stop_btn = 1'b0;  // Press for 4 cycles
    repeat (4) @(negedge sysclk);
    stop_btn = 1'b1;
    expect_byte(1'b0, got, found);
    if (found) check_byte("uart_tx byte", console_pkg::CH_PROMPT, got);
    check_bit("run", 1'b0, run);
    report_test("stop_button");
  endtask

  task automatic test_frame_error();
    exchange(random_char(), 1'b1, console_pkg::CH_ERROR);
    check_led("led", led_expect(1'b0, 1'b1), led);  // Error LED lit
    exchange(console_pkg::CH_RUN, 1'b0, console_pkg::CH_RUN);
    check_led("led", led_expect(1'b1, 1'b0), led);
    check_bit("run", 1'b1, run);
    report_test("frame_error");
  endtask

  task automatic test_baud_switch();
    console_pkg::byte_t c;
    exchange(console_pkg::CH_ESC, 1'b0, console_pkg::CH_PROMPT);  // Back to OPCOM
    check_bit("run", 1'b0, run);
    repeat (2 * bit_cycles(baud_sel)) @(negedge sysclk);  // Let the prompt finish
    baud_sel = SEL_FAST;
    repeat (32) @(negedge sysclk);
    repeat (3) begin
      c = random_char();
      exchange(c, 1'b0, c);
    end
    check_bit("run", 1'b0, run);
    report_test("baud_switch");
  endtask

  initial begin
    int unsigned seed_ret;
    rst_n    = 1'b0;
    stop_btn = 1'b1;
    uart_rx  = 1'b1;  // Idle line
    baud_sel = SEL_DEF;
    seed_ret = $urandom(SEED);
    test_err_base = 0;
    repeat (2) @(negedge sysclk);
    rst_n = 1'b1;
    @(negedge sysclk);
    test_reset();
    test_opcom_echo();
    test_run_escape();
    test_stop_button();
    test_frame_error();
    test_baud_switch();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/console_pkg.sv
verilog/baud_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/console_ctrl.sv
verilog/led_driver.sv
verilog/nd_console_top.sv
verification/tb_nd_console_top.sv
